/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := nn_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
common/nn_pkg.sv
design/weight_store.sv
design/hidden_layer.sv
design/output_layer.sv
design/nn_top.sv
test/nn_assertions.sv
test/nn_tb.sv

/* common/nn_pkg.sv */
package nn_pkg;

	//------------------------------
	// widths and layer sizes
	//------------------------------
	localparam int DATA_WIDTH = 16;                   // sample, weight, hidden, out
	localparam int ACC_WIDTH  = 40;                   // four full products plus headroom
	localparam int INPUT_DIM  = 4;                    // samples per data point
	localparam int HIDDEN_DIM = 3;                    // hidden neurons
	localparam int W1_COUNT   = INPUT_DIM * HIDDEN_DIM; // layer-1 weights
	localparam int W2_COUNT   = 3;                    // layer-2 weights

	//------------------------------
	// types
	//------------------------------
	typedef logic signed [DATA_WIDTH-1:0] fixed_t;           // fixed point value
	typedef logic signed [ACC_WIDTH-1:0]  acc_t;             // full precision sum
	typedef logic [$clog2(INPUT_DIM)-1:0] sample_idx_t;      // sample position in point

	// fixed_t limits at accumulator width
	localparam acc_t FIXED_MAX_ACC = acc_t'((2 ** (DATA_WIDTH - 1)) - 1);
	localparam acc_t FIXED_MIN_ACC = acc_t'(-(2 ** (DATA_WIDTH - 1)));

	//------------------------------
	// narrowing
	//------------------------------
	// drops frac fraction bits, then clamps to the fixed_t range
	function automatic fixed_t fixed_narrow(input acc_t value, input int frac);
		acc_t shifted;
		shifted = value >>> frac; // arithmetic, keeps sign
		if (shifted > FIXED_MAX_ACC) begin
			return FIXED_MAX_ACC[DATA_WIDTH-1:0]; // clamp high
		end
		else if (shifted < FIXED_MIN_ACC) begin
			return FIXED_MIN_ACC[DATA_WIDTH-1:0]; // clamp low
		end
		else begin
			return shifted[DATA_WIDTH-1:0]; // in range
		end
	endfunction

endpackage

/* design/hidden_layer.sv */
`timescale 1ns/10ps

module hidden_layer #(
	parameter int FRAC_BITS = 8 // binary point position
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           in_valid_d,
	input  nn_pkg::fixed_t data_point,
	input  nn_pkg::fixed_t w1 [nn_pkg::W1_COUNT],
	output nn_pkg::fixed_t hidden [nn_pkg::HIDDEN_DIM],
	output logic           hidden_valid
);

	import nn_pkg::*;

	sample_idx_t idx; // position of current sample in point

	//------------------------------
	// sample indexing
	//------------------------------
	// a gap in in_valid_d throws away a partial point
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
		end
		else if (in_valid_d) begin
			idx <= idx + 1'b1; // wraps after last sample
		end
		else begin
			idx <= '0; // burst broken
		end
	end

	// pulse after the edge that takes the last sample
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hidden_valid <= 1'b0;
		end
		else begin
			hidden_valid <= in_valid_d && (idx == sample_idx_t'(INPUT_DIM - 1));
		end
	end

	//------------------------------
	// neuron lanes
	//------------------------------
	for (genvar j = 0; j < HIDDEN_DIM; j++) begin : g_lane
		acc_t prod; // sample times selected weight
		acc_t acc;  // running sum for neuron j

		// weight 4j+i pairs with sample i
		always_comb begin
			prod = acc_t'(data_point) * acc_t'(w1[j * INPUT_DIM + int'(idx)]);
		end

		// fresh start at index 0 lets points run back to back
		always_ff @(posedge clk) begin
			if (in_valid_d) begin
				if (idx == '0) begin
					acc <= prod; // first sample
				end
				else begin
					acc <= acc + prod;
				end
			end
		end

		// relu, then back to fixed_t
		always_comb begin
			hidden[j] = (acc > 0) ? fixed_narrow(acc, FRAC_BITS) : '0;
		end
	end

endmodule

/* design/nn_top.sv */
`timescale 1ns/10ps

module nn_top #(
	parameter int FRAC_BITS = 8 // fraction bits of every fixed_t
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           in_valid_d,  // sample strobe
	input  logic           in_valid_w1, // layer-1 weight shift strobe
	input  logic           in_valid_w2, // layer-2 weight shift strobe
	input  nn_pkg::fixed_t data_point,
	input  nn_pkg::fixed_t weight1,
	input  nn_pkg::fixed_t weight2,
	output logic           out_valid,
	output nn_pkg::fixed_t out
);

	import nn_pkg::*;

	//------------------------------
	// internal buses
	//------------------------------
	fixed_t w1_regs [W1_COUNT];   // layer-1 weights, index 4j+i
	fixed_t w2_regs [W2_COUNT];   // layer-2 weights
	fixed_t hidden  [HIDDEN_DIM]; // relu outputs
	logic   hidden_valid;         // one cycle pulse

	//------------------------------
	// blocks
	//------------------------------
	weight_store weight_store_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid_w1 (in_valid_w1),
		.in_valid_w2 (in_valid_w2),
		.weight1     (weight1),
		.weight2     (weight2),
		.w1          (w1_regs),
		.w2          (w2_regs)
	);

	hidden_layer #(.FRAC_BITS(FRAC_BITS)) hidden_layer_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid_d   (in_valid_d),
		.data_point   (data_point),
		.w1           (w1_regs),
		.hidden       (hidden),
		.hidden_valid (hidden_valid)
	);

	// one edge after hidden_valid, so out lands at c+5
	output_layer #(.FRAC_BITS(FRAC_BITS)) output_layer_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.hidden_valid (hidden_valid),
		.hidden       (hidden),
		.w2           (w2_regs),
		.out          (out),
		.out_valid    (out_valid)
	);

endmodule

/* design/output_layer.sv */
`timescale 1ns/10ps

module output_layer #(
	parameter int FRAC_BITS = 8 // binary point position
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           hidden_valid,
	input  nn_pkg::fixed_t hidden [nn_pkg::HIDDEN_DIM],
	input  nn_pkg::fixed_t w2 [nn_pkg::W2_COUNT],
	output nn_pkg::fixed_t out,
	output logic           out_valid
);

	import nn_pkg::*;

	acc_t sum; // full precision weighted sum

	//------------------------------
	// weighted sum
	//------------------------------
	always_comb begin
		sum = '0;
		for (int j = 0; j < HIDDEN_DIM; j++) begin
			sum = sum + acc_t'(hidden[j]) * acc_t'(w2[j]); // no relu here
		end
	end

	//------------------------------
	// output register
	//------------------------------
	// out only carries data in the out_valid cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out       <= '0;
			out_valid <= 1'b0;
		end
		else if (hidden_valid) begin
			out       <= fixed_narrow(sum, FRAC_BITS); // shift and clamp
			out_valid <= 1'b1;
		end
		else begin
			out       <= '0; // nothing held
			out_valid <= 1'b0;
		end
	end

endmodule

/* design/weight_store.sv */
`timescale 1ns/10ps

module weight_store (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           in_valid_w1,
	input  logic           in_valid_w2,
	input  nn_pkg::fixed_t weight1,
	input  nn_pkg::fixed_t weight2,
	output nn_pkg::fixed_t w1 [nn_pkg::W1_COUNT],
	output nn_pkg::fixed_t w2 [nn_pkg::W2_COUNT]
);

	import nn_pkg::*;

	//------------------------------
	// layer-1 chain
	//------------------------------
	// new weight enters at the top, first one sent ends at index 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < W1_COUNT; i++) begin
				w1[i] <= '0; // all weights zero
			end
		end
		else if (in_valid_w1) begin
			for (int i = 0; i < W1_COUNT - 1; i++) begin
				w1[i] <= w1[i+1]; // shift toward 0
			end
			w1[W1_COUNT-1] <= weight1; // newest
		end
	end

	//------------------------------
	// layer-2 chain
	//------------------------------
	// independent of layer 1, reload either alone
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < W2_COUNT; i++) begin
				w2[i] <= '0;
			end
		end
		else if (in_valid_w2) begin
			for (int i = 0; i < W2_COUNT - 1; i++) begin
				w2[i] <= w2[i+1]; // shift toward 0
			end
			w2[W2_COUNT-1] <= weight2; // newest
		end
	end

endmodule

/* test/nn_assertions.sv */
`timescale 1ns/10ps

module nn_assertions (
	input logic           clk,
	input logic           rst_n,
	input logic           in_valid_d,
	input logic           in_valid_w1,
	input logic           in_valid_w2,
	input logic           out_valid,
	input nn_pkg::fixed_t out
);

	import nn_pkg::*;

	sample_idx_t sample_cnt; // own count of samples in the burst
	logic        last_sample;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_cnt <= '0;
		end
		else if (in_valid_d) begin
			sample_cnt <= sample_cnt + 1'b1;
		end
		else begin
			sample_cnt <= '0; // gap drops partial point
		end
	end

	assign last_sample = in_valid_d && (sample_cnt == sample_idx_t'(INPUT_DIM - 1));

	//------------------------------
	// port checks
	//------------------------------
	single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid)
		else $error("out_valid high on two cycles in a row");

	no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(in_valid_d && (in_valid_w1 || in_valid_w2)))
		else $error("samples and weight loading overlap");

	out_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> (out == '0))
		else $error("out nonzero while out_valid is low");

	// fourth sample at c+3, result at c+5
	latency: assert property (@(posedge clk) disable iff (!rst_n)
		last_sample |-> ##2 out_valid)
		else $error("out_valid missing two cycles after the fourth sample");

endmodule

bind nn_top nn_assertions nn_assertions_i (
	.clk         (clk),
	.rst_n       (rst_n),
	.in_valid_d  (in_valid_d),
	.in_valid_w1 (in_valid_w1),
	.in_valid_w2 (in_valid_w2),
	.out_valid   (out_valid),
	.out         (out)
);

/* test/nn_tb.sv */
`timescale 1ns/10ps

module nn_tb;

	import nn_pkg::*;

	parameter int FRAC_BITS = 8; // tb copy, handed to the DUT

	//------------------------------
	// run length
	//------------------------------
	localparam int RESET_CYCLES = 16;
	localparam int LOAD_CYCLES  = W1_COUNT + W2_COUNT + 2;  // both chains plus gaps
	localparam int POINT_CYCLES = INPUT_DIM + 10;           // burst, latency, drain
	localparam int TEST_CYCLES  = RESET_CYCLES
		+ 2 * (LOAD_CYCLES + POINT_CYCLES)                  // single point, relu
		+ LOAD_CYCLES + W2_COUNT + 1 + 2 * POINT_CYCLES     // saturation
		+ LOAD_CYCLES + 5 * INPUT_DIM + POINT_CYCLES        // streaming
		+ 3 + POINT_CYCLES                                  // partial burst
		+ W2_COUNT + 1 + POINT_CYCLES;                      // weight reload
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	localparam longint FIX_MAX = (longint'(1) <<< (DATA_WIDTH - 1)) - longint'(1);
	localparam longint FIX_MIN = -(longint'(1) <<< (DATA_WIDTH - 1));

	logic   clk;
	logic   rst_n;
	logic   in_valid_d;
	logic   in_valid_w1;
	logic   in_valid_w2;
	fixed_t data_point;
	fixed_t weight1;
	fixed_t weight2;
	logic   out_valid;
	fixed_t out;

	int unsigned cycle_count;  // bumped just before each rising edge
	int          error_count;
	int          check_count;

	fixed_t      w1_model [W1_COUNT];  // weights as loaded into the DUT
	fixed_t      w2_model [W2_COUNT];
	fixed_t      pt       [INPUT_DIM]; // current data point
	fixed_t      saved_pt [INPUT_DIM]; // point from the first test
	fixed_t      exp_val_q [$];        // expected out values, in order
	int unsigned exp_cyc_q [$];        // cycle each one is due

	nn_top #(.FRAC_BITS(FRAC_BITS)) dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid_d  (in_valid_d),
		.in_valid_w1 (in_valid_w1),
		.in_valid_w2 (in_valid_w2),
		.data_point  (data_point),
		.weight1     (weight1),
		.weight2     (weight2),
		.out_valid   (out_valid),
		.out         (out)
	);

	initial begin
		clk = 1'b0;
		cycle_count = 0;
		forever begin
			#10;
			cycle_count = cycle_count + 1; // visible to everything woken by the edge
			clk = 1'b1;
			#10;
			clk = 1'b0;
		end
	end

	//------------------------------
	// reference model
	//------------------------------
	function automatic fixed_t narrow_model(input longint value);
		longint shifted;
		shifted = value >>> FRAC_BITS; // drop fraction bits
		if (shifted > FIX_MAX) begin
			return fixed_t'(FIX_MAX[DATA_WIDTH-1:0]);
		end
		else if (shifted < FIX_MIN) begin
			return fixed_t'(FIX_MIN[DATA_WIDTH-1:0]);
		end
		return fixed_t'(shifted[DATA_WIDTH-1:0]);
	endfunction

	function automatic fixed_t hidden_model(input int j);
		longint sum;
		sum = '0;
		for (int i = 0; i < INPUT_DIM; i++) begin
			sum += longint'(pt[i]) * longint'(w1_model[j * INPUT_DIM + i]);
		end
		if (sum > longint'(0)) begin
			return narrow_model(sum);
		end
		return '0; // relu
	endfunction

	function automatic fixed_t model_out();
		longint sum;
		sum = '0;
		for (int j = 0; j < HIDDEN_DIM; j++) begin
			sum += longint'(hidden_model(j)) * longint'(w2_model[j]);
		end
		return narrow_model(sum); // no relu on output
	endfunction

	function automatic fixed_t rand_small();
		int unsigned r;
		r = $urandom_range(1023);
		return fixed_t'(int'(r) - 512); // about -2.0 to 2.0 at 8 fraction bits
	endfunction

	//------------------------------
	// drivers and checks
	//------------------------------
	task automatic check_fixed(input string name, input fixed_t expected, input fixed_t actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Error: %s expected 0x%h got 0x%h", name, expected, actual);
		end
	endtask

	task automatic load_layer1();
		for (int i = 0; i < W1_COUNT; i++) begin
			@(posedge clk);
			in_valid_w1 <= 1'b1;
			weight1     <= w1_model[i]; // index 0 goes first
		end
		@(posedge clk);
		in_valid_w1 <= 1'b0;
		weight1     <= '0;
	endtask

	task automatic load_layer2();
		for (int i = 0; i < W2_COUNT; i++) begin
			@(posedge clk);
			in_valid_w2 <= 1'b1;
			weight2     <= w2_model[i];
		end
		@(posedge clk);
		in_valid_w2 <= 1'b0;
		weight2     <= '0;
	endtask

	// leaves in_valid_d high so points can follow back to back
	task automatic send_point(input fixed_t expected);
		for (int i = 0; i < INPUT_DIM; i++) begin
			@(posedge clk);
			if (i == 0) begin
				exp_val_q.push_back(expected);
				exp_cyc_q.push_back(cycle_count + 5); // due in c+5
			end
			in_valid_d <= 1'b1;
			data_point <= pt[i];
		end
	endtask

	task automatic end_burst();
		@(posedge clk);
		in_valid_d <= 1'b0;
		data_point <= '0;
	endtask

	task automatic wait_outputs();
		while (exp_val_q.size() > 0) begin
			@(negedge clk); // monitor pops or flags each one
		end
		repeat (2) @(negedge clk); // room for a stray out_valid
	endtask

	// out and out_valid are settled by the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_valid) begin
				if (exp_val_q.size() == 0) begin
					error_count++;
					$display("out_valid high in cycle %0d with no data point pending", cycle_count);
				end
				else begin
					if (exp_cyc_q[0] != cycle_count) begin
						error_count++;
						$display("out_valid came in cycle %0d, it was due in cycle %0d",
							cycle_count, exp_cyc_q[0]);
					end
					check_fixed("out", exp_val_q.pop_front(), out);
					void'(exp_cyc_q.pop_front());
				end
			end
			else if (exp_cyc_q.size() > 0 && cycle_count >= exp_cyc_q[0]) begin
				error_count++;
				$display("out_valid missing, it was due in cycle %0d", exp_cyc_q[0]);
				void'(exp_val_q.pop_front());
				void'(exp_cyc_q.pop_front());
			end
		end
	end

	//------------------------------
	// directed tests
	//------------------------------
	task automatic single_point();
		foreach (w1_model[i]) w1_model[i] = rand_small();
		foreach (w2_model[i]) w2_model[i] = rand_small();
		foreach (pt[i]) pt[i] = rand_small();
		saved_pt = pt; // reused by the reload test
		load_layer1();
		load_layer2();
		send_point(model_out());
		end_burst();
		wait_outputs();
	endtask

	task automatic relu_masking();
		fixed_t expected;
		pt[0] = 16'sd256; // 1.0
		pt[1] = 16'sd512;
		pt[2] = 16'sd128;
		pt[3] = 16'sd384;
		for (int i = 0; i < W1_COUNT; i++) begin
			// positive lane 0, lanes 1 and 2 go negative
			w1_model[i] = (i < INPUT_DIM) ? fixed_t'($urandom_range(255) + 1)
				: -fixed_t'($urandom_range(255) + 1);
		end
		foreach (w2_model[i]) w2_model[i] = rand_small();
		load_layer1();
		load_layer2();
		expected = narrow_model(longint'(hidden_model(0)) * longint'(w2_model[0]));
		send_point(expected); // only neuron 0 contributes
		end_burst();
		wait_outputs();
	endtask

	task automatic saturation();
		foreach (pt[i]) pt[i] = 16'sh7fff;
		foreach (w1_model[i]) w1_model[i] = 16'sh7fff;
		foreach (w2_model[i]) w2_model[i] = 16'sh7fff;
		load_layer1();
		load_layer2();
		send_point(16'sh7fff); // clamps at fixed_t max
		end_burst();
		wait_outputs();
		foreach (w2_model[i]) w2_model[i] = 16'sh8000; // most negative weight
		load_layer2();
		send_point(16'sh8000); // clamps at fixed_t min
		end_burst();
		wait_outputs();
	endtask

	task automatic streaming();
		foreach (w1_model[i]) w1_model[i] = rand_small();
		foreach (w2_model[i]) w2_model[i] = rand_small();
		load_layer1();
		load_layer2();
		for (int p = 0; p < 5; p++) begin
			foreach (pt[i]) pt[i] = rand_small();
			send_point(model_out()); // no gap between points
		end
		end_burst();
		wait_outputs();
	endtask

	task automatic partial_burst();
		for (int i = 0; i < 2; i++) begin
			@(posedge clk);
			in_valid_d <= 1'b1;
			data_point <= rand_small(); // discarded samples
		end
		end_burst();
		foreach (pt[i]) pt[i] = rand_small();
		send_point(model_out());
		end_burst();
		wait_outputs();
	endtask

	task automatic weight_reload();
		foreach (w2_model[i]) w2_model[i] = rand_small();
		load_layer2(); // layer 1 stays as loaded
		pt = saved_pt;
		send_point(model_out());
		end_burst();
		wait_outputs();
	endtask

	//------------------------------
	// main sequence
	//------------------------------
	initial begin
		void'($urandom(32'hc199));
		error_count = 0;
		check_count = 0;
		rst_n       = 1'b0;
		in_valid_d  = 1'b0;
		in_valid_w1 = 1'b0;
		in_valid_w2 = 1'b0;
		data_point  = '0;
		weight1     = '0;
		weight2     = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		single_point();
		relu_masking();
		saturation();
		streaming();
		partial_burst();
		weight_reload();
		$display("checks: %0d  errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TESTBENCH PASSED");
		end
		else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("timeout, run still busy after %0d cycles", cycle_count);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
